// File: common/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Predictor sizing shared by the packages and the RTL

// BTB index bits, giving 64 direct-mapped entries
`define BP_BTB_INDEX_WIDTH 6

// Global history length
// Also sets the PHT index width, 16 counters
`define BP_HISTORY_WIDTH 4

// Fetch address out of reset
`define BP_RESET_PC 32'h0000_0000

`endif

// File: common/pc_addr_pkg.sv
`default_nettype none

`include "bp_defs.svh"

package pc_addr_pkg;

    // Tag is whatever lies above the BTB index and the byte offset
    localparam int unsigned BTB_TAG_WIDTH = 32 - `BP_BTB_INDEX_WIDTH - 2;

    typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;

    // Fetch address as the BTB decodes it
    typedef struct packed {
        btb_tag_t                       tag;
        logic [`BP_BTB_INDEX_WIDTH-1:0] index;
        logic [1:0]                     offset; // Byte offset, always zero
    } btb_view_t;

    // Fetch address as the gshare PHT decodes it
    typedef struct packed {
        logic [29-`BP_HISTORY_WIDTH:0]  upper;    // Unused by the PHT
        logic [`BP_HISTORY_WIDTH-1:0]   pc_field; // XORed with history
        logic [1:0]                     offset;
    } pht_view_t;

    // One fetch word, two decodings
    typedef union packed {
        btb_view_t btb;
        pht_view_t pht;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: common/bp_pkg.sv
`default_nettype none

`include "bp_defs.svh"

package bp_pkg;

    // Global history, newest outcome in bit 0
    typedef logic [`BP_HISTORY_WIDTH-1:0] ghr_t;

    // 2-bit saturating counter, MSB is the taken prediction
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } sat_cnt_t;

    // Next fetch address source
    typedef enum logic [1:0] {
        SEQ         = 2'b00, // PC + 4
        RESOLVE_SEQ = 2'b01, // Resolved PC + 4, taken branch was predicted
        PREDICT     = 2'b10, // BTB target
        RESOLVE_TGT = 2'b11  // Resolved target
    } next_pc_sel_t;

endpackage

`default_nettype wire

// File: branch_predictor/btb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module btb (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  pc_addr_pkg::fetch_addr_u rd_addr_i,   // Fetch PC
    input  pc_addr_pkg::fetch_addr_u wr_addr_i,   // Resolved branch PC
    input  logic                     wr_en_i,
    input  logic [31:0]              wr_target_i,
    output logic                     hit_o,
    output logic [31:0]              target_o
);

    import pc_addr_pkg::*;

    localparam int unsigned ENTRIES = 1 << `BP_BTB_INDEX_WIDTH;

    logic [ENTRIES-1:0] valid_q;
    btb_tag_t           tag_q    [ENTRIES];
    logic [31:0]        target_q [ENTRIES];

    logic [`BP_BTB_INDEX_WIDTH-1:0] rd_idx;
    logic [`BP_BTB_INDEX_WIDTH-1:0] wr_idx;

    assign rd_idx = rd_addr_i.btb.index;
    assign wr_idx = wr_addr_i.btb.index;

    // Valid bits are the only state that needs clearing
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_addr_i.btb.tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

    // Read before write, a same-cycle write is seen next cycle
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_addr_i.btb.tag);
    assign target_o = target_q[rd_idx];

endmodule

`default_nettype wire

// File: branch_predictor/gshare_pht.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module gshare_pht (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  pc_addr_pkg::fetch_addr_u rd_addr_i,
    input  pc_addr_pkg::fetch_addr_u upd_addr_i,
    input  logic                     upd_en_i,
    input  logic                     upd_taken_i,
    input  bp_pkg::ghr_t             upd_ghr_i,   // History seen at fetch of this branch
    output logic                     taken_o,
    output bp_pkg::ghr_t             ghr_o
);

    import bp_pkg::*;

    localparam int unsigned ENTRIES = 1 << `BP_HISTORY_WIDTH;

    sat_cnt_t pht_q [ENTRIES];
    ghr_t     ghr_q;

    ghr_t     rd_idx;
    ghr_t     upd_idx;
    sat_cnt_t upd_cnt;
    sat_cnt_t upd_cnt_next;

    // Gshare hashing
    assign rd_idx  = rd_addr_i.pht.pc_field ^ ghr_q;
    assign upd_idx = upd_addr_i.pht.pc_field ^ upd_ghr_i; // Same index the fetch used

    assign taken_o = (pht_q[rd_idx] == CNT_WEAK_T) || (pht_q[rd_idx] == CNT_STRONG_T);
    assign ghr_o   = ghr_q;

    // Saturating step
    always_comb begin
        upd_cnt      = pht_q[upd_idx];
        upd_cnt_next = upd_cnt;
        if (upd_taken_i) begin
            if (upd_cnt != CNT_STRONG_T) begin
                upd_cnt_next = sat_cnt_t'(upd_cnt + 2'd1);
            end
        end else if (upd_cnt != CNT_STRONG_NT) begin
            upd_cnt_next = sat_cnt_t'(upd_cnt - 2'd1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht_q[i] <= CNT_WEAK_NT;
            end
            ghr_q <= '0;
        end else if (upd_en_i) begin
            pht_q[upd_idx] <= upd_cnt_next;
            // Oldest outcome drops off the top
            ghr_q <= {ghr_q[`BP_HISTORY_WIDTH-2:0], upd_taken_i};
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module fetch_pc_gen (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     stall_i,
    input  bp_pkg::next_pc_sel_t     next_pc_sel_i,
    input  logic [31:0]              btb_target_i,
    input  logic [31:0]              resolve_pc_i,
    input  logic [31:0]              resolve_target_i,
    output pc_addr_pkg::fetch_addr_u pc_o
);

    import pc_addr_pkg::*;
    import bp_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic [31:0] resolve_plus4;
    logic [31:0] pc_next;
    logic        redirect;

    assign pc_plus4      = pc_q + 32'd4;
    assign resolve_plus4 = resolve_pc_i + 32'd4; // Fall-through of a wrongly taken branch

    always_comb begin
        case (next_pc_sel_i)
            SEQ:         pc_next = pc_plus4;
            RESOLVE_SEQ: pc_next = resolve_plus4;
            PREDICT:     pc_next = btb_target_i;
            default:     pc_next = resolve_target_i;
        endcase
    end

    // A redirect must not be lost to a stall
    assign redirect = (next_pc_sel_i == RESOLVE_SEQ) || (next_pc_sel_i == RESOLVE_TGT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= `BP_RESET_PC;
        end else if (!stall_i || redirect) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = fetch_addr_u'(pc_q);

endmodule

`default_nettype wire

// File: verilog/mispredict_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mispredict_unit (
    input  logic                 resolve_valid_i,
    input  logic                 resolve_taken_i,   // Actual outcome
    input  logic                 resolve_pred_i,    // Prediction made at fetch
    input  logic                 resolve_btb_hit_i,
    input  logic                 btb_hit_i,
    input  logic                 pht_taken_i,
    output logic                 pred_taken_o,
    output logic                 flush_o,
    output logic                 wr_en_o,           // BTB write
    output bp_pkg::next_pc_sel_t next_pc_sel_o
);

    import bp_pkg::*;

    logic resolve_pred;
    logic mispredict;

    // Only a BTB hit can redirect fetch
    assign pred_taken_o = btb_hit_i && pht_taken_i;

    // Prediction at fetch was only effective with a BTB hit
    assign resolve_pred = resolve_pred_i && resolve_btb_hit_i;
    assign mispredict   = resolve_valid_i && (resolve_taken_i != resolve_pred);

    assign flush_o = mispredict;
    assign wr_en_o = resolve_valid_i && resolve_taken_i; // Taken branches only

    // Resolve redirect wins over fetch prediction
    always_comb begin
        if (mispredict) begin
            next_pc_sel_o = resolve_taken_i ? RESOLVE_TGT : RESOLVE_SEQ;
        end else if (pred_taken_o) begin
            next_pc_sel_o = PREDICT;
        end else begin
            next_pc_sel_o = SEQ;
        end
    end

endmodule

`default_nettype wire

// File: verilog/bp_top.sv
`timescale 1ns/1ps
`default_nettype none

module bp_top (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         stall_i,           // Holds the PC only
    input  logic         resolve_valid_i,
    input  logic         resolve_taken_i,
    input  logic         resolve_btb_hit_i,
    input  logic         resolve_pred_i,
    input  logic [31:0]  resolve_pc_i,
    input  logic [31:0]  resolve_target_i,
    input  bp_pkg::ghr_t resolve_ghr_i,
    output logic [31:0]  fetch_pc_o,
    output logic         pred_taken_o,
    output logic         btb_hit_o,
    output logic         flush_o,
    output bp_pkg::ghr_t ghr_o
);

    import pc_addr_pkg::*;
    import bp_pkg::*;

    fetch_addr_u  fetch_pc;
    fetch_addr_u  resolve_addr;
    logic [31:0]  btb_target;
    logic         pht_taken;
    logic         btb_wr_en;
    next_pc_sel_t next_pc_sel;

    assign fetch_pc_o   = fetch_pc;
    assign resolve_addr = resolve_pc_i;

    fetch_pc_gen u_fetch_pc_gen (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stall_i          (stall_i),
        .next_pc_sel_i    (next_pc_sel),
        .btb_target_i     (btb_target),
        .resolve_pc_i     (resolve_pc_i),
        .resolve_target_i (resolve_target_i),
        .pc_o             (fetch_pc)
    );

    btb u_btb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_addr_i   (fetch_pc),
        .wr_addr_i   (resolve_addr),
        .wr_en_i     (btb_wr_en),
        .wr_target_i (resolve_target_i),
        .hit_o       (btb_hit_o),
        .target_o    (btb_target)
    );

    // History and counters update on every resolve
    gshare_pht u_gshare_pht (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_addr_i   (fetch_pc),
        .upd_addr_i  (resolve_addr),
        .upd_en_i    (resolve_valid_i),
        .upd_taken_i (resolve_taken_i),
        .upd_ghr_i   (resolve_ghr_i),
        .taken_o     (pht_taken),
        .ghr_o       (ghr_o)
    );

    mispredict_unit u_mispredict_unit (
        .resolve_valid_i   (resolve_valid_i),
        .resolve_taken_i   (resolve_taken_i),
        .resolve_pred_i    (resolve_pred_i),
        .resolve_btb_hit_i (resolve_btb_hit_i),
        .btb_hit_i         (btb_hit_o),
        .pht_taken_i       (pht_taken),
        .pred_taken_o      (pred_taken_o),
        .flush_o           (flush_o),
        .wr_en_o           (btb_wr_en),
        .next_pc_sel_o     (next_pc_sel)
    );

endmodule

`default_nettype wire

// File: verification/bp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module bp_tb;

    import bp_pkg::*;

    localparam int IW = `BP_BTB_INDEX_WIDTH;
    localparam int HW = `BP_HISTORY_WIDTH;
    localparam int TW = 32 - IW - 2;

    logic clk_i, rst_ni, stall_i, resolve_valid_i, resolve_taken_i;
    logic resolve_btb_hit_i, resolve_pred_i;
    logic [31:0] resolve_pc_i, resolve_target_i, fetch_pc_o;
    ghr_t resolve_ghr_i, ghr_o, exp_ghr, br_ghr;
    logic pred_taken_o, btb_hit_o, flush_o;

    // Reference model state
    logic [31:0] m_pc, m_next;
    logic        m_valid  [1 << IW];
    logic [TW-1:0] m_tag  [1 << IW];
    logic [31:0] m_target [1 << IW];
    logic [1:0]  m_pht    [1 << HW];
    ghr_t        m_ghr;

    integer seed = 32'hb9dbc7b0;
    int errors, checks, tests_run, tests_bad, mark;
    string cur_test;
    logic [31:0] br_pc;
    logic br_hit, br_pred, br_live;

    bp_top dut0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .stall_i(stall_i),
        .resolve_valid_i(resolve_valid_i), .resolve_taken_i(resolve_taken_i),
        .resolve_btb_hit_i(resolve_btb_hit_i), .resolve_pred_i(resolve_pred_i),
        .resolve_pc_i(resolve_pc_i), .resolve_target_i(resolve_target_i),
        .resolve_ghr_i(resolve_ghr_i), .fetch_pc_o(fetch_pc_o),
        .pred_taken_o(pred_taken_o), .btb_hit_o(btb_hit_o),
        .flush_o(flush_o), .ghr_o(ghr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check_pc(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_ghr(input string what, input ghr_t exp, input ghr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // Next fetch PC and fetch prediction from the model state and current inputs
    function automatic logic [31:0] ref_next_pc(output logic hit, output logic pred,
                                                output logic flush);
        logic [IW-1:0] bi;
        logic [HW-1:0] pi;
        bi    = m_pc[IW+1:2];
        pi    = m_pc[HW+1:2] ^ m_ghr;
        hit   = m_valid[bi] && (m_tag[bi] == m_pc[31:IW+2]);
        pred  = hit && (m_pht[pi] >= 2'd2);
        flush = resolve_valid_i && (resolve_taken_i != resolve_pred_i);
        if (flush) return resolve_taken_i ? resolve_target_i : resolve_pc_i + 32'd4;
        if (stall_i) return m_pc;
        if (pred) return m_target[bi];
        return m_pc + 32'd4;
    endfunction

    task automatic ref_update();
        logic [IW-1:0] bi;
        logic [HW-1:0] pi;
        m_pc = m_next;
        if (resolve_valid_i) begin
            bi = resolve_pc_i[IW+1:2];
            pi = resolve_pc_i[HW+1:2] ^ resolve_ghr_i; // Snapshot taken at fetch
            if (resolve_taken_i && m_pht[pi] != 2'd3) m_pht[pi] = m_pht[pi] + 2'd1;
            if (!resolve_taken_i && m_pht[pi] != 2'd0) m_pht[pi] = m_pht[pi] - 2'd1;
            m_ghr = {m_ghr[HW-2:0], resolve_taken_i};
            if (resolve_taken_i) begin
                m_valid[bi]  = 1'b1;
                m_tag[bi]    = resolve_pc_i[31:IW+2];
                m_target[bi] = resolve_target_i;
            end
        end
    endtask

    // Model comparison on every cycle out of reset
    initial begin : compare_proc
        logic active;
        logic exp_hit, exp_pred, exp_flush;
        m_pc  = `BP_RESET_PC;
        m_ghr = '0;
        for (int i = 0; i < (1 << IW); i++) m_valid[i] = 1'b0;
        for (int i = 0; i < (1 << HW); i++) m_pht[i] = 2'd1; // Weak not-taken
        forever begin
            @(negedge clk_i);
            active = rst_ni;
            if (active) begin
                m_next = ref_next_pc(exp_hit, exp_pred, exp_flush);
                check_pc("model fetch_pc", m_pc, fetch_pc_o);
                check_flag("model btb_hit", exp_hit, btb_hit_o);
                check_flag("model pred_taken", exp_pred, pred_taken_o);
                check_flag("model flush", exp_flush, flush_o);
                check_ghr("model ghr", m_ghr, ghr_o);
            end
            @(posedge clk_i);
            if (active) ref_update();
        end
    end

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic settle();
        @(negedge clk_i);
    endtask

    task automatic wait_for_pc(input logic [31:0] pc, input int limit);
        int n;
        n = 0;
        while (fetch_pc_o !== pc && n < limit) begin
            step();
            n++;
        end
        if (fetch_pc_o !== pc) begin
            errors++;
            $display("%s: fetch PC never reached %h within %0d cycles", cur_test, pc, limit);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        mark     = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != mark) tests_bad++;
        $display("test %-12s %s (%0d errors)", cur_test, (errors == mark) ? "ok" : "bad",
                 errors - mark);
    endtask

    task automatic drive_resolve(input logic [31:0] pc, input logic [31:0] tgt, input logic taken,
                                 input logic hit, input logic pred, input ghr_t snap);
        resolve_valid_i   = 1'b1;
        resolve_pc_i      = pc;
        resolve_target_i  = tgt;
        resolve_taken_i   = taken;
        resolve_btb_hit_i = hit;
        resolve_pred_i    = pred;
        resolve_ghr_i     = snap;
    endtask

    // Fixed per-branch target inside the low 512 bytes
    function automatic logic [31:0] target_of(input logic [31:0] pc);
        return {23'd0, pc[8:2] ^ 7'h2a, 2'b00};
    endfunction

    initial begin
        rst_ni = 1'b0;
        stall_i = 1'b0;
        drive_resolve(32'd0, 32'd0, 1'b0, 1'b0, 1'b0, '0);
        resolve_valid_i = 1'b0;
        exp_ghr = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        begin_test("reset_seq");
        for (int i = 0; i < 4; i++) begin
            settle();
            check_pc("fetch_pc", 32'(4 * i), fetch_pc_o);
            check_flag("btb_hit", 1'b0, btb_hit_o);
            check_flag("pred_taken", 1'b0, pred_taken_o);
            step();
        end
        end_test();

        begin_test("stall");
        stall_i = 1'b1;
        repeat (3) begin
            settle();
            check_pc("fetch_pc", 32'd16, fetch_pc_o);
            step();
        end
        stall_i = 1'b0;
        settle();
        step();
        settle();
        check_pc("fetch_pc", 32'd20, fetch_pc_o);
        end_test();

        begin_test("flush_taken");
        step();
        drive_resolve(32'h80, 32'h60, 1'b1, 1'b0, 1'b0, exp_ghr); // Backward branch
        settle();
        check_flag("flush", 1'b1, flush_o);
        step();
        resolve_valid_i = 1'b0;
        exp_ghr = {exp_ghr[HW-2:0], 1'b1};
        settle();
        check_pc("fetch_pc", 32'h60, fetch_pc_o);
        check_ghr("ghr", exp_ghr, ghr_o);
        end_test();

        // History saturates to all ones so the last update lands on the read index
        begin_test("btb_train");
        step();
        for (int k = 0; k < HW; k++) begin
            drive_resolve(32'h80, 32'h60, 1'b1, 1'b0, 1'b0, exp_ghr);
            settle();
            check_flag("flush", 1'b1, flush_o);
            step();
            exp_ghr = {exp_ghr[HW-2:0], 1'b1};
        end
        resolve_valid_i = 1'b0;
        wait_for_pc(32'h80, 32);
        settle();
        check_ghr("ghr", exp_ghr, ghr_o);
        check_flag("btb_hit", 1'b1, btb_hit_o);
        check_flag("pred_taken", 1'b1, pred_taken_o);
        check_flag("flush", 1'b0, flush_o);
        step();
        settle();
        check_pc("fetch_pc", 32'h60, fetch_pc_o);
        end_test();

        begin_test("flush_not_tkn");
        step();
        drive_resolve(32'h80, 32'h60, 1'b0, 1'b1, 1'b1, exp_ghr);
        settle();
        check_flag("flush", 1'b1, flush_o);
        step();
        resolve_valid_i = 1'b0;
        exp_ghr = {exp_ghr[HW-2:0], 1'b0};
        settle();
        check_pc("fetch_pc", 32'h84, fetch_pc_o);
        check_ghr("ghr", exp_ghr, ghr_o);
        end_test();

        // Fetched prediction comes back as a resolve one cycle later
        begin_test("random");
        for (int n = 0; n < 400; n++) begin
            settle();
            br_pc   = fetch_pc_o;
            br_hit  = btb_hit_o;
            br_pred = pred_taken_o;
            br_ghr  = ghr_o;
            br_live = !flush_o; // Wrong-path fetch is dropped
            step();
            stall_i = (($random(seed) & 3) == 0);
            drive_resolve(br_pc, target_of(br_pc), (($random(seed) & 7) < (br_pc[4] ? 6 : 1)),
                          br_hit, br_pred, br_ghr);
            resolve_valid_i = br_live && (($random(seed) & 1) == 1);
        end
        resolve_valid_i = 1'b0;
        stall_i = 1'b0;
        step();
        settle();
        end_test();

        $display("%0d tests run, %0d bad, %0d checks, %0d errors", tests_run, tests_bad,
                 checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/pc_addr_pkg.sv
common/bp_pkg.sv
branch_predictor/btb.sv
branch_predictor/gshare_pht.sv
verilog/fetch_pc_gen.sv
verilog/mispredict_unit.sv
verilog/bp_top.sv
verification/bp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module bp_tb -Mdir obj_dir -o bp_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/bp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
